// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module tb_rv32i_core -Mdir obj_dir -f build.f
	./obj_dir/Vtb_rv32i_core | tee /dev/stderr | grep -q "No errors"

clean:
	rm -rf obj_dir

// ==== build.f ====
hw/rv32i_pkg.sv
hw/control_unit.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/alu.sv
hw/load_store_unit.sv
hw/pc_unit.sv
hw/rv32i_core.sv
tb/tb_rv32i_core.sv

// ==== hw/alu.sv ====
`default_nettype none

module alu import rv32i_pkg::*; (
	input  logic [3:0]      alu_op,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic [XLEN-1:0] result,
	output logic            cond
);

	logic [4:0] shamt;
	logic       eq;
	logic       lt;
	logic       ltu;

	assign shamt = b[4:0];
	assign eq    = (a == b);
	assign lt    = ($signed(a) < $signed(b));
	assign ltu   = (a < b);

	// Compare outcome, also feeds SLT and SLTU
	always_comb begin
		case (alu_op)
			ALU_EQ:   cond = eq;
			ALU_NE:   cond = !eq;
			ALU_SLT:  cond = lt;
			ALU_GE:   cond = !lt;
			ALU_SLTU: cond = ltu;
			ALU_GEU:  cond = !ltu;
			default:  cond = 1'b0;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_XOR:    result = a ^ b;
			ALU_OR:     result = a | b;
			ALU_AND:    result = a & b;
			ALU_SLL:    result = a << shamt;
			ALU_SRL:    result = a >> shamt;
			ALU_SRA:    result = $signed(a) >>> shamt;
			ALU_SLT,
			ALU_SLTU:   result = {{(XLEN-1){1'b0}}, cond};
			ALU_PASS_B: result = b;
			default:    result = '0; // Branch compares only use cond
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/control_unit.sv ====
`default_nettype none

module control_unit import rv32i_pkg::*; (
	input  instr_u     instr,
	output logic [3:0] alu_op,
	output logic       a_sel_pc,
	output logic       b_sel_imm,
	output logic [2:0] imm_sel,
	output logic       reg_we,
	output logic [1:0] wb_sel,
	output logic       mem_we,
	output logic [1:0] mem_size,
	output logic       mem_unsigned,
	output logic       branch,
	output logic       jump,
	output logic       jump_reg
);

	logic [2:0] funct3;
	logic       alt; // funct7 bit 5, SUB and SRA/SRAI
	logic [3:0] arith_op;

	assign funct3 = instr.r_fmt.funct3;
	assign alt    = instr.r_fmt.funct7[5];

	// Shared by OP and OP-IMM
	always_comb begin
		case (funct3)
			3'b000:  arith_op = ALU_ADD;
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	always_comb begin
		// Defaults give a no-operation
		alu_op       = ALU_ADD;
		a_sel_pc     = 1'b0;
		b_sel_imm    = 1'b0;
		imm_sel      = IMM_I;
		reg_we       = 1'b0;
		wb_sel       = WB_ALU;
		mem_we       = 1'b0;
		mem_size     = MEM_WORD;
		mem_unsigned = 1'b0;
		branch       = 1'b0;
		jump         = 1'b0;
		jump_reg     = 1'b0;
		case (instr.r_fmt.opcode)
			OPC_LUI: begin
				alu_op    = ALU_PASS_B;
				b_sel_imm = 1'b1;
				imm_sel   = IMM_U;
				reg_we    = 1'b1;
			end
			OPC_AUIPC: begin
				a_sel_pc  = 1'b1;
				b_sel_imm = 1'b1;
				imm_sel   = IMM_U;
				reg_we    = 1'b1;
			end
			OPC_JAL: begin
				a_sel_pc  = 1'b1; // Target is pc + imm
				b_sel_imm = 1'b1;
				imm_sel   = IMM_J;
				reg_we    = 1'b1;
				wb_sel    = WB_PC4;
				jump      = 1'b1;
			end
			OPC_JALR: begin
				b_sel_imm = 1'b1;
				reg_we    = 1'b1;
				wb_sel    = WB_PC4;
				jump      = 1'b1;
				jump_reg  = 1'b1;
			end
			OPC_BRANCH: begin
				imm_sel = IMM_B;
				branch  = 1'b1;
				case (funct3)
					3'b000:  alu_op = ALU_EQ;
					3'b001:  alu_op = ALU_NE;
					3'b100:  alu_op = ALU_SLT;
					3'b101:  alu_op = ALU_GE;
					3'b110:  alu_op = ALU_SLTU;
					3'b111:  alu_op = ALU_GEU;
					default: branch = 1'b0; // Reserved encodings fall through
				endcase
			end
			OPC_LOAD: begin
				b_sel_imm    = 1'b1;
				reg_we       = 1'b1;
				wb_sel       = WB_MEM;
				mem_size     = funct3[1:0];
				mem_unsigned = funct3[2]; // LBU, LHU
			end
			OPC_STORE: begin
				b_sel_imm = 1'b1;
				imm_sel   = IMM_S;
				mem_we    = 1'b1;
				mem_size  = funct3[1:0];
			end
			OPC_OP_IMM: begin
				alu_op    = arith_op; // No SUBI, alt only matters for SRAI
				b_sel_imm = 1'b1;
				reg_we    = 1'b1;
			end
			OPC_OP: begin
				alu_op = (funct3 == 3'b000 && alt) ? ALU_SUB : arith_op;
				reg_we = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/imm_gen.sv ====
`default_nettype none

module imm_gen import rv32i_pkg::*; (
	input  instr_u            instr,
	input  logic [2:0]        imm_sel,
	output logic [XLEN-1:0]   imm
);

	always_comb begin
		case (imm_sel)
			IMM_I: imm = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
			IMM_S: imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
			              instr.s_fmt.imm_4_0};
			IMM_B: imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
			              instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
			              instr.b_fmt.imm_4_1, 1'b0}; // Halfword offset
			IMM_U: imm = {instr.u_fmt.imm_31_12, 12'b0};
			IMM_J: imm = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
			              instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
			              instr.j_fmt.imm_10_1, 1'b0};
			default: imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/load_store_unit.sv ====
`default_nettype none

module load_store_unit import rv32i_pkg::*; (
	input  logic [XLEN-1:0] addr,
	input  logic [XLEN-1:0] store_data,
	input  logic            mem_we,
	input  logic [1:0]      mem_size,
	input  logic            mem_unsigned,
	input  logic [XLEN-1:0] dmem_rdata,
	output logic [XLEN-1:0] dmem_addr,
	output logic [XLEN-1:0] dmem_wdata,
	output logic [3:0]      dmem_strb,
	output logic            dmem_we,
	output logic [XLEN-1:0] load_data
);

	logic [XLEN-1:0] lane; // Addressed bytes moved down to bit 0

	assign dmem_addr = {addr[XLEN-1:2], 2'b00};
	assign dmem_we   = mem_we;

	// Store side replicates the value, strobes pick the lane
	always_comb begin
		case (mem_size)
			MEM_BYTE: begin
				dmem_wdata = {4{store_data[7:0]}};
				dmem_strb  = 4'b0001 << addr[1:0];
			end
			MEM_HALF: begin
				dmem_wdata = {2{store_data[15:0]}};
				dmem_strb  = addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				dmem_wdata = store_data;
				dmem_strb  = 4'b1111;
			end
		endcase
		if (!mem_we) begin
			dmem_strb = 4'b0000;
		end
	end

	assign lane = dmem_rdata >> {addr[1:0], 3'b000};

	always_comb begin
		case (mem_size)
			MEM_BYTE: load_data = mem_unsigned ? {24'b0, lane[7:0]} :
			                                     {{24{lane[7]}}, lane[7:0]};
			MEM_HALF: load_data = mem_unsigned ? {16'b0, lane[15:0]} :
			                                     {{16{lane[15]}}, lane[15:0]};
			default:  load_data = dmem_rdata;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/pc_unit.sv ====
`default_nettype none

module pc_unit import rv32i_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            branch,
	input  logic            jump,
	input  logic            jump_reg,
	input  logic            cond,
	input  logic [XLEN-1:0] target,
	output logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] pc_plus4
);

	logic            redirect;
	logic [XLEN-1:0] next_pc;

	assign pc_plus4 = pc + 32'd4;
	assign redirect = jump || (branch && cond);

	always_comb begin
		if (!redirect) begin
			next_pc = pc_plus4;
		end else if (jump_reg) begin
			next_pc = {target[XLEN-1:1], 1'b0}; // JALR drops bit 0
		end else begin
			next_pc = target;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else begin
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`default_nettype none

module reg_file import rv32i_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic [4:0]      rs1_addr,
	input  logic [4:0]      rs2_addr,
	input  logic [4:0]      rd_addr,
	input  logic [XLEN-1:0] rd_data,
	input  logic            reg_we,
	output logic [XLEN-1:0] rs1_data,
	output logic [XLEN-1:0] rs2_data
);

	logic [XLEN-1:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_we && rd_addr != 5'd0) begin
			regs[rd_addr] <= rd_data;
		end
	end

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== hw/rv32i_core.sv ====
`default_nettype none

module rv32i_core import rv32i_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic [XLEN-1:0] imem_rdata,
	input  logic [XLEN-1:0] dmem_rdata,
	output logic [XLEN-1:0] imem_addr,
	output logic [XLEN-1:0] dmem_addr,
	output logic [XLEN-1:0] dmem_wdata,
	output logic [3:0]      dmem_strb,
	output logic            dmem_we
);

	instr_u          instr;
	logic [3:0]      alu_op;
	logic            a_sel_pc;
	logic            b_sel_imm;
	logic [2:0]      imm_sel;
	logic            reg_we;
	logic [1:0]      wb_sel;
	logic            mem_we;
	logic [1:0]      mem_size;
	logic            mem_unsigned;
	logic            branch;
	logic            jump;
	logic            jump_reg;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_result;
	logic            cond;
	logic [XLEN-1:0] load_data;
	logic [XLEN-1:0] rd_data;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_target;
	logic            store_en;

	assign imem_addr = pc;
	assign instr     = imem_rdata;

	control_unit u_control (
		.instr(instr), .alu_op(alu_op), .a_sel_pc(a_sel_pc), .b_sel_imm(b_sel_imm),
		.imm_sel(imm_sel), .reg_we(reg_we), .wb_sel(wb_sel), .mem_we(mem_we),
		.mem_size(mem_size), .mem_unsigned(mem_unsigned), .branch(branch),
		.jump(jump), .jump_reg(jump_reg)
	);

	imm_gen u_imm (.instr(instr), .imm_sel(imm_sel), .imm(imm));

	reg_file u_regs (
		.clk(clk), .rst(rst), .rs1_addr(instr.r_fmt.rs1), .rs2_addr(instr.r_fmt.rs2),
		.rd_addr(instr.r_fmt.rd), .rd_data(rd_data), .reg_we(reg_we),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	assign op_a = a_sel_pc ? pc : rs1_data;
	assign op_b = b_sel_imm ? imm : rs2_data;

	alu u_alu (.alu_op(alu_op), .a(op_a), .b(op_b), .result(alu_result), .cond(cond));

	// ALU is busy comparing rs1 and rs2 on branches, so the target has its own adder
	assign pc_target = branch ? (pc + imm) : alu_result;

	pc_unit u_pc (
		.clk(clk), .rst(rst), .branch(branch), .jump(jump), .jump_reg(jump_reg),
		.cond(cond), .target(pc_target), .pc(pc), .pc_plus4(pc_plus4)
	);

	assign store_en = mem_we && !rst; // No stores while held in reset

	load_store_unit u_lsu (
		.addr(alu_result), .store_data(rs2_data), .mem_we(store_en),
		.mem_size(mem_size), .mem_unsigned(mem_unsigned), .dmem_rdata(dmem_rdata),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_strb(dmem_strb),
		.dmem_we(dmem_we), .load_data(load_data)
	);

	always_comb begin
		case (wb_sel)
			WB_MEM:  rd_data = load_data;
			WB_PC4:  rd_data = pc_plus4; // Link value for JAL and JALR
			default: rd_data = alu_result;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

	localparam int unsigned XLEN = 32;
	localparam logic [XLEN-1:0] RESET_PC = '0;

	// RV32I major opcodes
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	localparam logic [3:0] ALU_ADD    = 4'b0000;
	localparam logic [3:0] ALU_SUB    = 4'b0001;
	localparam logic [3:0] ALU_XOR    = 4'b0010;
	localparam logic [3:0] ALU_OR     = 4'b0011;
	localparam logic [3:0] ALU_AND    = 4'b0100;
	localparam logic [3:0] ALU_SLTU   = 4'b0101;
	localparam logic [3:0] ALU_SLT    = 4'b0110;
	localparam logic [3:0] ALU_SLL    = 4'b0111;
	localparam logic [3:0] ALU_SRL    = 4'b1000;
	localparam logic [3:0] ALU_SRA    = 4'b1001;
	localparam logic [3:0] ALU_EQ     = 4'b1010; // Branch compares from here
	localparam logic [3:0] ALU_NE     = 4'b1011;
	localparam logic [3:0] ALU_GEU    = 4'b1100;
	localparam logic [3:0] ALU_GE     = 4'b1101;
	localparam logic [3:0] ALU_PASS_B = 4'b1110; // LUI

	localparam logic [1:0] WB_ALU = 2'd0;
	localparam logic [1:0] WB_MEM = 2'd1;
	localparam logic [1:0] WB_PC4 = 2'd2; // Link address

	// Same encoding as funct3[1:0] of loads and stores
	localparam logic [1:0] MEM_BYTE = 2'd0;
	localparam logic [1:0] MEM_HALF = 2'd1;
	localparam logic [1:0] MEM_WORD = 2'd2;

	localparam logic [2:0] IMM_I = 3'd0;
	localparam logic [2:0] IMM_S = 3'd1;
	localparam logic [2:0] IMM_B = 3'd2;
	localparam logic [2:0] IMM_U = 3'd3;
	localparam logic [2:0] IMM_J = 3'd4;

	// One instruction word seen through each encoding format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm_11_0;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_4_0;
			logic [6:0] opcode;
		} s_fmt;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm_31_12;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u_fmt;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
	} instr_u;

endpackage

`default_nettype wire

// ==== tb/tb_rv32i_core.sv ====
`default_nettype none

module tb_rv32i_core import rv32i_pkg::*; ();

	timeunit 1ns;
	timeprecision 10ps;

	localparam int RUN_CYCLES = 64; // Longest program plus margin
	localparam int TESTS = 6;
	localparam int TIMEOUT_NS = TESTS * (RUN_CYCLES + 20) * 4 + 400;

	logic            clk;
	logic            rst;
	logic [XLEN-1:0] imem_addr;
	logic [XLEN-1:0] imem_rdata;
	logic [XLEN-1:0] dmem_addr;
	logic [XLEN-1:0] dmem_rdata;
	logic [XLEN-1:0] dmem_wdata;
	logic [3:0]      dmem_strb;
	logic            dmem_we;

	logic [XLEN-1:0] imem [0:255];
	logic [XLEN-1:0] dmem [0:255];
	logic [XLEN-1:0] prog [$];
	logic [XLEN-1:0] expq [$]; // Expected words at 0x100 onward
	logic [3:0]      strb_log [$];
	integer          seed = 32'h862e;
	int              errors = 0;
	int              checks = 0;

	rv32i_core DUT (
		.clk(clk), .rst(rst), .imem_rdata(imem_rdata), .dmem_rdata(dmem_rdata),
		.imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.dmem_strb(dmem_strb), .dmem_we(dmem_we)
	);

	assign imem_rdata = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	always @(posedge clk) begin
		if (dmem_we) begin
			for (int i = 0; i < 4; i++) begin
				if (dmem_strb[i]) begin
					dmem[dmem_addr[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
				end
			end
			strb_log.push_back(dmem_strb);
		end
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Simulation timed out before the tests finished");
		$display("Errors found");
		$finish;
	end

	function automatic logic [31:0] fill_word(int idx);
		logic [7:0] i8;
		i8 = idx[7:0];
		return {i8 ^ 8'ha5, 8'h3c, ~i8, i8};
	endfunction

	function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
	                                       logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
	                                       logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
	                                       logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
	                                       logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	// RV32I branch conditions
	function automatic logic branch_rule(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic emit_li(logic [4:0] rd, logic [31:0] v);
		logic [31:0] upper;
		upper = v + 32'h800; // Compensates the sign of the low part
		prog.push_back(u_type(upper[31:12], rd, OPC_LUI));
		prog.push_back(i_type(v[11:0], rd, 3'b000, rd, OPC_OP_IMM));
	endtask

	task automatic emit_sw(logic [4:0] rs2, int addr);
		prog.push_back(s_type(12'(addr), rs2, 5'd0, 3'b010));
	endtask

	task automatic emit_result(logic [4:0] rs2, logic [31:0] expv);
		emit_sw(rs2, 'h100 + 4 * expq.size());
		expq.push_back(expv);
	endtask

	task automatic check_word(string name, logic [XLEN-1:0] expv, logic [XLEN-1:0] act);
		checks++;
		if (expv !== act) begin
			errors++;
			$display("mismatch %s: expected %h, got %h", name, expv, act);
		end
	endtask

	task automatic check_strb(string name, logic [3:0] expv, logic [3:0] act);
		checks++;
		if (expv !== act) begin
			errors++;
			$display("mismatch %s: expected %h, got %h", name, expv, act);
		end
	endtask

	task automatic check_results(string tag);
		for (int i = 0; i < expq.size(); i++) begin
			check_word($sformatf("%s dmem[%h]", tag, 'h100 + 4 * i), expq[i], dmem[64 + i]);
		end
	endtask

	task automatic check_write_count(string tag, int expected);
		checks++;
		if (strb_log.size() != expected) begin
			errors++;
			$display("%s test saw %0d data writes instead of %0d", tag, strb_log.size(),
			         expected);
		end
	endtask

	// Loads memories under reset, then runs the program
	task automatic run_program();
		int n;
		n = prog.size() + 8;
		if (n > RUN_CYCLES) begin
			errors++;
			$display("Program of %0d words does not fit the cycle budget", prog.size());
			n = RUN_CYCLES;
		end
		@(posedge clk);
		#1 rst = 1'b1;
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : 32'h0000006f; // jal x0, 0 parks the core
			dmem[i] = fill_word(i);
		end
		strb_log.delete();
		repeat (16) @(posedge clk);
		#1 rst = 1'b0;
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] sx;
		logic [11:0] imm;
		logic [4:0]  sh;
		a = $random(seed);
		b = $random(seed);
		r = $random(seed);
		imm = r[11:0];
		sh = r[16:12];
		sx = {{20{imm[11]}}, imm};
		prog.delete();
		expq.delete();
		emit_li(5'd1, a);
		emit_li(5'd2, b);
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		emit_result(5'd3, a + b);
		prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
		emit_result(5'd3, a - b);
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3));
		emit_result(5'd3, a ^ b);
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd3));
		emit_result(5'd3, a | b);
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3));
		emit_result(5'd3, a & b);
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd3));
		emit_result(5'd3, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd3));
		emit_result(5'd3, (a < b) ? 32'd1 : 32'd0);
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd3));
		emit_result(5'd3, a << b[4:0]);
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd3));
		emit_result(5'd3, a >> b[4:0]);
		prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd3));
		emit_result(5'd3, $signed(a) >>> b[4:0]);
		prog.push_back(i_type(imm, 5'd1, 3'b000, 5'd3, OPC_OP_IMM));
		emit_result(5'd3, a + sx);
		prog.push_back(i_type({7'h20, sh}, 5'd1, 3'b101, 5'd3, OPC_OP_IMM)); // SRAI
		emit_result(5'd3, $signed(a) >>> sh);
		prog.push_back(i_type(imm, 5'd1, 3'b010, 5'd3, OPC_OP_IMM));
		emit_result(5'd3, ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0);
		prog.push_back(i_type(imm, 5'd1, 3'b100, 5'd3, OPC_OP_IMM));
		emit_result(5'd3, a ^ sx);
		run_program();
		check_results("alu");
	endtask

	task automatic emit_load(logic [2:0] f3, int off, logic [31:0] expv);
		prog.push_back(i_type(12'('h200 + off), 5'd0, f3, 5'd3, OPC_LOAD));
		emit_result(5'd3, expv);
	endtask

	task automatic test_loads();
		logic [31:0] r;
		logic [31:0] w;
		logic [31:0] sft;
		r = $random(seed);
		// Bytes 0 and 3 negative, 1 and 2 positive
		w = {1'b1, r[30:24], 1'b0, r[22:16], 1'b0, r[14:8], 1'b1, r[6:0]};
		prog.delete();
		expq.delete();
		emit_li(5'd1, w);
		emit_sw(5'd1, 'h200);
		for (int k = 0; k < 4; k++) begin
			sft = w >> (8 * k);
			emit_load(3'b000, k, {{24{sft[7]}}, sft[7:0]});
			emit_load(3'b100, k, {24'b0, sft[7:0]});
		end
		for (int k = 0; k < 4; k += 2) begin
			sft = w >> (8 * k);
			emit_load(3'b001, k, {{16{sft[15]}}, sft[15:0]});
			emit_load(3'b101, k, {16'b0, sft[15:0]});
		end
		emit_load(3'b010, 0, w);
		run_program();
		check_results("load");
	endtask

	task automatic test_stores();
		logic [31:0] v;
		logic [31:0] w;
		logic [31:0] exp_words [7];
		logic [3:0]  exp_strb [7];
		int          idx [7];
		v = $random(seed);
		prog.delete();
		emit_li(5'd1, v);
		for (int k = 0; k < 4; k++) begin
			prog.push_back(s_type(12'('h380 + 5 * k), 5'd1, 5'd0, 3'b000));
			idx[k] = ('h380 >> 2) + k;
			w = fill_word(idx[k]);
			w[8*k +: 8] = v[7:0];
			exp_words[k] = w;
			exp_strb[k] = 4'(1 << k);
		end
		for (int j = 0; j < 2; j++) begin
			prog.push_back(s_type(12'('h390 + 6 * j), 5'd1, 5'd0, 3'b001));
			idx[4+j] = ('h390 >> 2) + j;
			w = fill_word(idx[4+j]);
			w[16*j +: 16] = v[15:0];
			exp_words[4+j] = w;
			exp_strb[4+j] = j ? 4'b1100 : 4'b0011;
		end
		emit_sw(5'd1, 'h398);
		idx[6] = 'h398 >> 2;
		exp_words[6] = v;
		exp_strb[6] = 4'b1111;
		run_program();
		check_write_count("store", 7);
		for (int i = 0; i < 7; i++) begin
			if (i < strb_log.size()) begin
				check_strb($sformatf("dmem_strb of store %0d", i), exp_strb[i], strb_log[i]);
			end
			check_word($sformatf("store dmem[%h]", idx[i] * 4), exp_words[i], dmem[idx[i]]);
		end
	endtask

	task automatic test_branches();
		logic [2:0]  f3;
		logic [4:0]  rsa;
		logic [4:0]  rsb;
		logic [31:0] va;
		logic [31:0] vb;
		prog.delete();
		expq.delete();
		emit_li(5'd1, 32'hfffffffb);
		prog.push_back(i_type(12'd3, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
		prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd5, OPC_OP_IMM)); // Fall-through marker
		prog.push_back(i_type(12'd2, 5'd0, 3'b000, 5'd6, OPC_OP_IMM)); // Taken marker
		for (int c = 0; c < 12; c++) begin
			case (c / 2)
				0: f3 = 3'b000;
				1: f3 = 3'b001;
				2: f3 = 3'b100;
				3: f3 = 3'b101;
				4: f3 = 3'b110;
				default: f3 = 3'b111;
			endcase
			rsa = (c % 2 == 0) ? 5'd1 : 5'd2;
			rsb = (c % 2 == 0) ? 5'd2 : 5'd1;
			if (c < 4 && c % 2 == 1) begin
				rsa = 5'd1; // Equal operands for BEQ and BNE
			end
			va = (rsa == 5'd1) ? 32'hfffffffb : 32'd3;
			vb = (rsb == 5'd1) ? 32'hfffffffb : 32'd3;
			prog.push_back(b_type(13'd12, rsb, rsa, f3));
			emit_sw(5'd5, 'h100 + 4 * c);
			prog.push_back(j_type(21'd8, 5'd0));
			emit_sw(5'd6, 'h100 + 4 * c);
			expq.push_back(branch_rule(f3, va, vb) ? 32'd2 : 32'd1);
		end
		run_program();
		check_results("branch");
	endtask

	task automatic test_jumps();
		logic [31:0] r;
		logic [19:0] u1;
		logic [19:0] u2;
		r = $random(seed);
		u1 = r[19:0];
		u2 = r[31:12];
		prog.delete();
		expq.delete();
		prog.push_back(j_type(21'd8, 5'd7));
		prog.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd7, OPC_OP_IMM)); // Skipped
		emit_result(5'd7, 32'd4);
		prog.push_back(i_type(12'd25, 5'd0, 3'b000, 5'd8, OPC_OP_IMM)); // Odd target
		prog.push_back(i_type(12'd0, 5'd8, 3'b000, 5'd9, OPC_JALR));
		prog.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd9, OPC_OP_IMM)); // Skipped
		emit_result(5'd9, 32'd20);
		prog.push_back(u_type(u1, 5'd10, OPC_LUI));
		emit_result(5'd10, {u1, 12'b0});
		prog.push_back(u_type(u2, 5'd11, OPC_AUIPC)); // At address 36
		emit_result(5'd11, 32'd36 + {u2, 12'b0});
		run_program();
		check_results("jump");
	endtask

	task automatic test_unknown();
		logic [31:0] v;
		logic [31:0] r;
		v = $random(seed);
		r = $random(seed);
		prog.delete();
		expq.delete();
		emit_li(5'd12, v);
		prog.push_back({r[31:12], 5'd12, 7'b0001011}); // custom-0 opcode
		prog.push_back(i_type(12'd1, 5'd12, 3'b000, 5'd0, OPC_OP_IMM));
		emit_result(5'd12, v);
		emit_result(5'd0, 32'd0);
		run_program();
		check_write_count("unknown opcode", 2);
		check_results("unknown");
	endtask

	initial begin
		rst = 1'b1;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0000006f;
			dmem[i] = fill_word(i);
		end
		test_alu();
		test_loads();
		test_stores();
		test_branches();
		test_jumps();
		test_unknown();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
